// File: fp_adder.f
+incdir+logic
+incdir+testbench
logic/fp_pkg.sv
logic/fp_align_add.sv
logic/sum_fifo.sv
logic/fp_normalize.sv
logic/fp_round_pack.sv
logic/fp_adder.sv
testbench/fp_adder_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the adder testbench with Verilator, runs it and checks for a pass.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module fp_adder_tb -f fp_adder.f -o fp_adder_sim

output=$(./obj_dir/fp_adder_sim)
echo "$output"

if echo "$output" | grep -qx "TEST OK"; then
	exit 0
fi
exit 1

// File: testbench/fp_ref.svh
// Reference conversion from integers to single-precision bit patterns.
// Rounds to nearest even, for magnitudes below 2^30.
// Included inside the testbench module body.

`ifndef FP_REF_SVH
`define FP_REF_SVH

function automatic logic [31:0] to_single(input longint value);
	logic   sign;
	longint mag;
	longint kept;
	longint rest;
	longint half;
	int     msb;
	int     shift;
	int     biased;

	sign = (value < 0);
	mag  = sign ? -value : value;
	if (mag == 0) begin
		return 32'h0000_0000;
	end

	// Position of the leading one
	msb = 0;
	for (int i = 0; i < 31; i++) begin
		if (mag[i]) begin
			msb = i;
		end
	end
	biased = 127 + msb;

	if (msb <= 23) begin
		kept = mag << (23 - msb);
	end else begin
		shift = msb - 23;
		kept  = mag >> shift;
		rest  = mag & ((64'sd1 << shift) - 1);
		half  = 64'sd1 << (shift - 1);
		// Above half rounds up and exactly half goes to the even side
		if (rest > half || (rest == half && kept[0])) begin
			kept++;
		end
		if (kept == (64'sd1 << 24)) begin
			kept = kept >> 1;
			biased++;
		end
	end

	return {sign, biased[7:0], kept[22:0]};
endfunction

`endif

// File: testbench/fp_adder_tb.sv
// Testbench for the pipelined single-precision adder.
// Runs directed tests for integer sums, cancellation, deep normalization,
// rounding, overflow and back-pressure with credit flow control.
// Results are collected in order and compared against a reference
// conversion of the exact integer result or fixed expected words.

`timescale 1ns/1ns

`include "fp_settings.svh"

module fp_adder_tb;

	localparam int DEPTH     = `FP_FIFO_DEPTH;
	localparam int TOTAL_OPS = 57;

	logic        clk          = 1'b0;
	logic        reset        = 1'b1;
	logic [31:0] a            = '0;
	logic [31:0] b            = '0;
	logic        op           = 1'b0;
	logic        in_valid     = 1'b0;
	logic        in_ready;
	logic [31:0] result;
	logic        result_valid;
	logic        result_ready = 1'b1;

	logic [31:0] rx_q [$];
	logic [31:0] op_a_q [$];
	logic [31:0] op_b_q [$];
	logic        op_sel_q [$];
	logic [31:0] expected_q [$];

	int checks      = 0;
	int errors      = 0;
	int outstanding = 0;
	bit batch_done  = 1'b0;

	`include "fp_ref.svh"

	fp_adder fp_adder_i (
		.clk          (clk),
		.reset        (reset),
		.a            (a),
		.b            (b),
		.op           (op),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.result       (result),
		.result_valid (result_valid),
		.result_ready (result_ready)
	);

	always #50 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Result collector and in-flight tracking

	always @(posedge clk) begin
		if (!reset && result_valid && result_ready) begin
			rx_q.push_back(result);
		end
	end

	// At most the buffer slots plus the two consumer registers
	always @(posedge clk) begin : track_outstanding
		int count_next;
		if (reset) begin
			outstanding <= 0;
		end else begin
			count_next = outstanding + ((in_valid && in_ready) ? 1 : 0)
			           - ((result_valid && result_ready) ? 1 : 0);
			assert (count_next <= DEPTH + 2) else begin
				$display("Input accepted with no free slot, %0d operations in flight",
				         count_next);
				checks++;
				errors++;
			end
			outstanding <= count_next;
		end
	end

	initial begin : watchdog
		repeat (16 + TOTAL_OPS * 40) @(posedge clk);
		$display("Timeout: results did not arrive in time");
		$display("TEST FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Helpers

	task automatic check_word(input string name, input logic [31:0] expected,
	                          input logic [31:0] actual);
		checks++;
		assert (actual === expected) else begin
			$display("Error: %s expected %08h actual %08h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		checks++;
		assert (actual == expected) else begin
			$display("Error: %s expected %0d actual %0d", name, expected, actual);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err0);
		$display("%s: finished, %0d errors", name, errors - err0);
	endtask

	task automatic add_op(input logic [31:0] x, input logic [31:0] y, input logic sub,
	                      input logic [31:0] expected);
		op_a_q.push_back(x);
		op_b_q.push_back(y);
		op_sel_q.push_back(sub);
		expected_q.push_back(expected);
	endtask

	// Expected value is the exact integer result rounded once
	task automatic add_int_op(input longint x, input longint y, input logic sub);
		add_op(to_single(x), to_single(y), sub, to_single(sub ? x - y : x + y));
	endtask

	// Holds the operation until the unit takes it
	task automatic send_op(input logic [31:0] op_a, input logic [31:0] op_b,
	                       input logic sub);
		a        <= op_a;
		b        <= op_b;
		op       <= sub;
		in_valid <= 1'b1;
		do begin
			@(posedge clk);
		end while (!in_ready);
	endtask

	task automatic run_batch(input string name);
		int          n;
		logic [31:0] got;
		logic [31:0] want;
		n = expected_q.size();
		while (op_a_q.size() > 0) begin
			send_op(op_a_q.pop_front(), op_b_q.pop_front(), op_sel_q.pop_front());
		end
		in_valid <= 1'b0;
		while (rx_q.size() < n) begin
			@(posedge clk);
		end
		repeat (n) begin
			got  = rx_q.pop_front();
			want = expected_q.pop_front();
			check_word(name, want, got);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Tests

	task automatic integer_arith();
		int err0;
		int edges;
		err0 = errors;
		add_int_op(3, 5, 1'b0);
		send_op(op_a_q.pop_front(), op_b_q.pop_front(), op_sel_q.pop_front());
		in_valid <= 1'b0;
		// Valid after the fourth edge and first seen on the fifth
		edges = 0;
		do begin
			@(posedge clk);
			edges++;
		end while (!result_valid && edges < 10);
		check_count("latency", 5, edges);
		add_int_op(7, 12, 1'b1);
		add_int_op(-100, -28, 1'b0);
		add_int_op(1000, 1, 1'b1);
		add_int_op(12345, 678, 1'b0);
		add_int_op(-250, 6, 1'b1);
		run_batch("integer");
		report_test("integer", err0);
	endtask

	task automatic cancel_to_zero();
		int err0;
		err0 = errors;
		add_op(to_single(4096), to_single(4096), 1'b1, 32'h0000_0000);
		add_op(to_single(77), to_single(-77), 1'b0, 32'h0000_0000);
		add_op(32'h0000_0000, 32'h0000_0000, 1'b0, 32'h0000_0000);
		add_op(32'h0000_0000, to_single(-9999), 1'b0, to_single(-9999));
		run_batch("cancellation");
		report_test("cancellation", err0);
	endtask

	task automatic deep_normalize();
		int err0;
		err0 = errors;
		add_op(32'h3F80_0001, 32'h3F80_0000, 1'b1, 32'h3400_0000);
		add_op(32'h40C0_0000, 32'h40A0_0000, 1'b1, 32'h3F80_0000);
		run_batch("normalize");
		report_test("normalize", err0);
	endtask

	task automatic round_to_even();
		int err0;
		err0 = errors;
		add_int_op(64'd16777216, 1, 1'b0);
		add_int_op(64'd16777216, 3, 1'b0);
		add_int_op(64'd33554432, 1, 1'b0);
		run_batch("rounding");
		report_test("rounding", err0);
	endtask

	task automatic overflow_to_inf();
		int err0;
		err0 = errors;
		add_op(32'h7F7F_FFFF, 32'h7F7F_FFFF, 1'b0, 32'h7F80_0000);
		add_op(32'hFF7F_FFFF, 32'hFF7F_FFFF, 1'b0, 32'hFF80_0000);
		run_batch("overflow");
		report_test("overflow", err0);
	endtask

	task automatic backpressure_credits();
		int     err0;
		longint x;
		longint y;
		err0 = errors;
		for (int i = 0; i < 40; i++) begin
			x = $urandom_range(16777215);
			y = $urandom_range(16777215);
			if ($urandom_range(1) == 1) begin
				x = -x;
			end
			if ($urandom_range(1) == 1) begin
				y = -y;
			end
			add_int_op(x, y, 1'($urandom_range(1)));
		end
		batch_done = 1'b0;
		fork
			begin
				run_batch("backpressure");
				batch_done = 1'b1;
			end
			begin
				repeat (8) begin
					@(posedge clk);
					result_ready <= 1'($urandom_range(1));
				end
				@(posedge clk);
				result_ready <= 1'b0;
				repeat (20) @(posedge clk);
				#1;
				// Buffer full and both consumer registers held
				checks++;
				assert (!in_ready) else begin
					$display("backpressure: in_ready stayed high through the output stall");
					errors++;
				end
				check_count("backpressure", DEPTH + 2, outstanding);
				while (!batch_done) begin
					@(posedge clk);
					result_ready <= 1'($urandom_range(1));
				end
				result_ready <= 1'b1;
			end
		join
		// No duplicates trailing behind
		repeat (10) @(posedge clk);
		check_count("backpressure", 0, rx_q.size());
		report_test("backpressure", err0);
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		void'($urandom(32'hba00));
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		integer_arith();
		cancel_to_zero();
		deep_normalize();
		round_to_even();
		overflow_to_inf();
		backpressure_credits();

		$display("Summary: %0d checks passed, %0d failed", checks - errors, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: logic/fp_adder.sv
// Pipelined single-precision adder/subtractor, top level.
// op = 0 gives a + b, op = 1 gives a - b. Inputs transfer on
// in_valid && in_ready, results on result_valid && result_ready.
// Idle latency is four cycles from the accepting edge.

`timescale 1ns/1ns

`include "fp_settings.svh"

module fp_adder (
	input  logic                                     clk,
	input  logic                                     reset,
	input  logic [`FP_EXP_WIDTH+`FP_MAN_WIDTH:0]     a,
	input  logic [`FP_EXP_WIDTH+`FP_MAN_WIDTH:0]     b,
	input  logic                                     op,
	input  logic                                     in_valid,
	output logic                                     in_ready,
	output logic [`FP_EXP_WIDTH+`FP_MAN_WIDTH:0]     result,
	output logic                                     result_valid,
	input  logic                                     result_ready
);
	import fp_pkg::*;

	logic     push;
	fp_sum_t  push_data;
	logic     pop;
	logic     fifo_valid;
	fp_sum_t  fifo_data;
	logic     norm_valid;
	logic     norm_ready;
	fp_norm_t norm_data;
	fp_word_t result_word;

	assign result = result_word;

	////////////////////////////////////////////////////////////
	// Producer, buffer, consumer

	// Pop doubles as the credit return
	fp_align_add fp_align_add_i (
		.clk           (clk),
		.reset         (reset),
		.a             (a),
		.b             (b),
		.op            (op),
		.in_valid      (in_valid),
		.in_ready      (in_ready),
		.credit_return (pop),
		.push          (push),
		.push_data     (push_data)
	);

	sum_fifo #(
		.DEPTH (`FP_FIFO_DEPTH)
	) sum_fifo_i (
		.clk        (clk),
		.reset      (reset),
		.push       (push),
		.push_data  (push_data),
		.pop        (pop),
		.fifo_valid (fifo_valid),
		.fifo_data  (fifo_data)
	);

	fp_normalize fp_normalize_i (
		.clk        (clk),
		.reset      (reset),
		.fifo_valid (fifo_valid),
		.fifo_data  (fifo_data),
		.pop        (pop),
		.norm_ready (norm_ready),
		.norm_valid (norm_valid),
		.norm_data  (norm_data)
	);

	fp_round_pack fp_round_pack_i (
		.clk          (clk),
		.reset        (reset),
		.norm_valid   (norm_valid),
		.norm_data    (norm_data),
		.norm_ready   (norm_ready),
		.result       (result_word),
		.result_valid (result_valid),
		.result_ready (result_ready)
	);

endmodule

// File: logic/fp_round_pack.sv
// Second consumer stage: round to nearest even and pack the word.
// Overflow saturates to a signed infinity; underflow and exact zero
// both give +0. The result register holds until the sink takes it.

`timescale 1ns/1ns

`include "fp_settings.svh"

module fp_round_pack (
	input  logic             clk,
	input  logic             reset,
	input  logic             norm_valid,
	input  fp_pkg::fp_norm_t norm_data,
	output logic             norm_ready,
	output fp_pkg::fp_word_t result,
	output logic             result_valid,
	input  logic             result_ready
);
	import fp_pkg::*;

	localparam int EW = `FP_EXP_WIDTH;
	localparam int MW = `FP_MAN_WIDTH;

	logic                 guard;
	logic                 round_bit;
	logic                 sticky;
	logic                 round_up;
	logic [MW+1:0]        rounded;
	logic [MW-1:0]        frac;
	logic signed [EW+1:0] exp_final;
	fp_word_t             packed_word;

	assign guard     = norm_data.man[2];
	assign round_bit = norm_data.man[1];
	assign sticky    = norm_data.man[0];

	// Ties go to the even neighbour
	assign round_up = guard && (round_bit || sticky || norm_data.man[3]);
	assign rounded  = {1'b0, norm_data.man[MW+3:3]} + {{(MW+1){1'b0}}, round_up};

	// Rounding carry into a new leading bit bumps the exponent
	// and leaves the fraction all zero
	assign frac      = rounded[MW-1:0];
	assign exp_final = norm_data.exp + $signed({{(EW+1){1'b0}}, rounded[MW+1]});

	always_comb begin
		if (norm_data.zero || exp_final <= 0) begin
			packed_word = '0;
		end else if (exp_final >= $signed(10'((1 << EW) - 1))) begin
			packed_word.sign = norm_data.sign;
			packed_word.exp  = {EW{1'b1}};
			packed_word.frac = '0;
		end else begin
			packed_word.sign = norm_data.sign;
			packed_word.exp  = exp_final[EW-1:0];
			packed_word.frac = frac;
		end
	end

	////////////////////////////////////////////////////////////
	// Output register with back-pressure

	assign norm_ready = !result_valid || result_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
		end else if (norm_ready) begin
			result_valid <= norm_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (norm_valid && norm_ready) begin
			result <= packed_word;
		end
	end

endmodule

// File: logic/fp_normalize.sv
// First consumer stage: bring the sum back to a leading hidden bit.
// A carry out shifts right by one; otherwise the mantissa is shifted
// left by its leading-zero count and the exponent lowered to match.
// Pops the buffer head whenever its own register can take a value.

`timescale 1ns/1ns

`include "fp_settings.svh"

module fp_normalize (
	input  logic             clk,
	input  logic             reset,
	input  logic             fifo_valid,
	input  fp_pkg::fp_sum_t  fifo_data,
	output logic             pop,
	input  logic             norm_ready,
	output logic             norm_valid,
	output fp_pkg::fp_norm_t norm_data
);
	import fp_pkg::*;

	localparam int EW = `FP_EXP_WIDTH;
	// Width of the normalized mantissa with the hidden bit at the top
	localparam int NW = `FP_MAN_WIDTH + 4;

	logic [NW:0]          m;
	logic [4:0]           lz;
	logic [NW-2:0]        shifted;
	logic [NW-1:0]        man_next;
	logic signed [EW+1:0] exp_in;
	logic signed [EW+1:0] exp_next;

	assign m      = fifo_data.man;
	assign exp_in = $signed({1'b0, fifo_data.exp});

	// Take a new head when the register is empty or being drained
	assign pop = fifo_valid && (!norm_valid || norm_ready);

	// Leading zeros above sticky up to the highest set bit
	always_comb begin
		lz = '0;
		for (int i = 1; i < NW; i++) begin
			if (m[i]) begin
				lz = 5'(NW - 1 - i);
			end
		end
	end

	// Sticky stays in place while everything above it moves up
	assign shifted = m[NW-1:1] << lz;

	always_comb begin
		if (m[NW]) begin
			// Carry out drops one bit into sticky
			man_next = {m[NW:2], m[1] | m[0]};
			exp_next = exp_in + 10'sd1;
		end else begin
			man_next = {shifted, m[0]};
			exp_next = exp_in - $signed({5'b0, lz});
		end
	end

	////////////////////////////////////////////////////////////
	// Output register

	always_ff @(posedge clk) begin
		if (reset) begin
			norm_valid <= 1'b0;
		end else if (!norm_valid || norm_ready) begin
			norm_valid <= fifo_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			norm_data.sign <= fifo_data.sign;
			norm_data.exp  <= exp_next;
			norm_data.man  <= man_next;
			norm_data.zero <= fifo_data.zero;
		end
	end

endmodule

// File: logic/sum_fifo.sv
// Queue of unnormalized sums between producer and consumer.
// Writes never find it full because the producer spends a credit first.
// The head entry is shown combinationally; each pop frees a slot and
// is also returned to the producer as a credit.

`timescale 1ns/1ns

module sum_fifo #(
	parameter int DEPTH = 4
) (
	input  logic            clk,
	input  logic            reset,
	input  logic            push,
	input  fp_pkg::fp_sum_t push_data,
	input  logic            pop,
	output logic            fifo_valid,
	output fp_pkg::fp_sum_t fifo_data
);
	import fp_pkg::*;

	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int NW = $clog2(DEPTH + 1);

	fp_sum_t       mem [DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [NW-1:0] count;

	assign fifo_valid = (count != '0);
	assign fifo_data  = mem[rd_ptr];

	// Storage
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	////////////////////////////////////////////////////////////
	// Pointers and occupancy

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				if (wr_ptr == PW'(DEPTH - 1)) begin
					wr_ptr <= '0;
				end else begin
					wr_ptr <= wr_ptr + 1'b1;
				end
			end

			if (pop) begin
				if (rd_ptr == PW'(DEPTH - 1)) begin
					rd_ptr <= '0;
				end else begin
					rd_ptr <= rd_ptr + 1'b1;
				end
			end

			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: logic/fp_align_add.sv
// Producer side of the adder: unpack, align and add/subtract.
// Stage 1 orders the operands by magnitude and aligns the smaller one.
// Stage 2 adds or subtracts the mantissas and pushes into the sum buffer.
// Input is accepted only while a buffer credit is held, so every push
// has a free slot waiting for it.

`timescale 1ns/1ns

`include "fp_settings.svh"

module fp_align_add (
	input  logic             clk,
	input  logic             reset,
	input  fp_pkg::fp_word_t a,
	input  fp_pkg::fp_word_t b,
	input  logic             op,
	input  logic             in_valid,
	output logic             in_ready,
	input  logic             credit_return,
	output logic             push,
	output fp_pkg::fp_sum_t  push_data
);
	import fp_pkg::*;

	localparam int EW = `FP_EXP_WIDTH;
	localparam int MW = `FP_MAN_WIDTH;
	// Hidden bit, fraction and guard/round/sticky
	localparam int AW = MW + 4;
	localparam int CW = $clog2(`FP_FIFO_DEPTH + 1);

	logic          accept;
	logic [CW-1:0] credits;

	// Unpacked operands
	logic          b_sign;
	logic [MW:0]   a_sig;
	logic [MW:0]   b_sig;
	logic          a_bigger;

	logic          big_sign;
	logic          small_sign;
	logic [EW-1:0] big_exp;
	logic [EW-1:0] small_exp;
	logic [MW:0]   big_sig;
	logic [MW:0]   small_sig;

	logic [EW-1:0] exp_diff;
	logic [AW-1:0] small_ext;
	logic [AW-1:0] small_shift;
	logic          lost;

	// Stage 1 registers
	logic          s1_valid;
	logic          s1_sign;
	logic          s1_eff_sub;
	logic [EW-1:0] s1_exp;
	logic [AW-1:0] s1_big;
	logic [AW-1:0] s1_small;

	logic [AW:0]   sum;

	////////////////////////////////////////////////////////////
	// Credits

	assign in_ready = (credits != '0);
	assign accept   = in_valid && in_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			credits <= CW'(`FP_FIFO_DEPTH);
		end else begin
			case ({accept, credit_return})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Stage 1: unpack, swap, align

	// Subtraction is addition with b negated
	assign b_sign = b.sign ^ op;

	// Exponent 0 reads as zero and denormals are flushed
	assign a_sig = (a.exp == '0) ? '0 : {1'b1, a.frac};
	assign b_sig = (b.exp == '0) ? '0 : {1'b1, b.frac};

	assign a_bigger = {a.exp, a_sig} >= {b.exp, b_sig};

	assign big_sign   = a_bigger ? a.sign : b_sign;
	assign small_sign = a_bigger ? b_sign : a.sign;
	assign big_exp    = a_bigger ? a.exp  : b.exp;
	assign small_exp  = a_bigger ? b.exp  : a.exp;
	assign big_sig    = a_bigger ? a_sig  : b_sig;
	assign small_sig  = a_bigger ? b_sig  : a_sig;

	assign exp_diff  = big_exp - small_exp;
	assign small_ext = {small_sig, 3'b000};

	// Shifts past the width give zero
	assign small_shift = small_ext >> exp_diff;
	assign lost        = |(small_ext & ~({AW{1'b1}} << exp_diff));

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			s1_sign    <= big_sign;
			s1_eff_sub <= big_sign ^ small_sign;
			s1_exp     <= big_exp;
			s1_big     <= {big_sig, 3'b000};
			// Bits shifted out collapse into sticky
			s1_small   <= {small_shift[AW-1:1], small_shift[0] | lost};
		end
	end

	////////////////////////////////////////////////////////////
	// Stage 2: mantissa add or subtract

	// Big operand is never smaller, so the difference stays positive
	assign sum = s1_eff_sub ? ({1'b0, s1_big} - {1'b0, s1_small})
	                        : ({1'b0, s1_big} + {1'b0, s1_small});

	always_ff @(posedge clk) begin
		if (reset) begin
			push <= 1'b0;
		end else begin
			push <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (s1_valid) begin
			push_data.sign <= s1_sign;
			push_data.exp  <= {1'b0, s1_exp};
			push_data.man  <= sum;
			push_data.zero <= (sum == '0);
		end
	end

endmodule

// File: logic/fp_pkg.sv
// Shared types for the floating-point adder pipeline.
// Modules import this package by wildcard and use scoped names on ports.
// Widths follow the settings header.

`include "fp_settings.svh"

package fp_pkg;

	////////////////////////////////////////////////////////////
	// IEEE single-precision word
	typedef struct packed {
		logic                       sign;
		logic [`FP_EXP_WIDTH-1:0]   exp;
		logic [`FP_MAN_WIDTH-1:0]   frac;
	} fp_word_t;

	////////////////////////////////////////////////////////////
	// Unnormalized sum, producer to consumer
	// man = {carry, hidden, fraction, guard, round, sticky}
	typedef struct packed {
		logic                       sign;
		logic [`FP_EXP_WIDTH:0]     exp;
		logic [`FP_MAN_WIDTH+4:0]   man;
		logic                       zero;
	} fp_sum_t;

	////////////////////////////////////////////////////////////
	// Normalized value between the two consumer stages
	// Exponent is signed so underflow shows up as <= 0
	// man = {hidden, fraction, guard, round, sticky}
	typedef struct packed {
		logic                             sign;
		logic signed [`FP_EXP_WIDTH+1:0]  exp;
		logic [`FP_MAN_WIDTH+3:0]         man;
		logic                             zero;
	} fp_norm_t;

endpackage

// File: logic/fp_settings.svh
// Field widths and queue depth for the single-precision adder.
// Include this file wherever a width or the buffer depth is needed.
// The package builds its types from the same values.

`ifndef FP_SETTINGS_SVH
`define FP_SETTINGS_SVH

// Biased exponent width
`define FP_EXP_WIDTH 8

// Stored fraction width without the hidden bit
`define FP_MAN_WIDTH 23

// Sum buffer slots and initial producer credits
`define FP_FIFO_DEPTH 4

`endif
